/* design/fcmp_pkg.sv */
package fcmp_pkg;

    // Raw binary32 value and its fields
    typedef logic [31:0] fp32_t;
    typedef logic [7:0]  fexp_t;
    typedef logic [22:0] fman_t;

    typedef logic [31:0] apb_data_t;

    // Code 3 is not a legal command
    typedef enum logic [1:0] {
        CMP_FEQ = 2'd0,
        CMP_FLT = 2'd1,
        CMP_FLE = 2'd2
    } fcmp_op_e;

    typedef struct packed {
        logic sign;
        logic is_zero;
        logic is_nan;
        logic is_snan;
    } fp_class_t;

    typedef struct packed {
        logic     valid;
        fcmp_op_e op;
        fp32_t    a;
        fp32_t    b;
    } cmp_req_t;

    typedef struct packed {
        logic valid;
        logic res;
        logic nv;
    } cmp_rsp_t;

    // Byte offsets of the register map
    localparam logic [7:0] REG_OPA    = 8'h00;
    localparam logic [7:0] REG_OPB    = 8'h04;
    localparam logic [7:0] REG_CMD    = 8'h08;
    localparam logic [7:0] REG_RESULT = 8'h0C;
    localparam logic [7:0] REG_FFLAGS = 8'h10;

    // Bit positions inside REG_RESULT and REG_FFLAGS
    localparam int RESULT_RES_BIT  = 0;
    localparam int RESULT_DONE_BIT = 1;
    localparam int FFLAGS_NV_BIT   = 0;

endpackage

/* design/fp_classify.sv */
`timescale 1ns/1ps

module fp_classify (
    input  logic                 pclk,
    input  fcmp_pkg::fp32_t      a,
    output fcmp_pkg::fp_class_t  cls
);

    import fcmp_pkg::*;

    logic  sign_f;
    fexp_t exp_f;
    fman_t man_f;
    logic  exp_ones;
    logic  exp_zero;
    logic  man_zero;

    assign {sign_f, exp_f, man_f} = a;

    assign exp_ones = &exp_f;
    assign exp_zero = (exp_f == '0);
    assign man_zero = (man_f == '0);

    assign cls.sign    = sign_f;
    assign cls.is_zero = exp_zero && man_zero;
    assign cls.is_nan  = exp_ones && !man_zero;

    // The quiet bit is the top fraction bit; a NaN without it is signalling
    assign cls.is_snan = exp_ones && !man_zero && !man_f[22];

    // A signalling NaN must also be reported as a NaN
    snan_implies_nan: assert property (
        @(posedge pclk) cls.is_snan |-> cls.is_nan
    );

endmodule

/* design/fp_compare.sv */
`timescale 1ns/1ps

module fp_compare (
    input  logic               pclk,
    input  logic               rst_n,
    input  fcmp_pkg::cmp_req_t cmp_req,
    output fcmp_pkg::cmp_rsp_t cmp_rsp
);

    import fcmp_pkg::*;

    fp_class_t   cls_a;
    fp_class_t   cls_b;
    logic [30:0] mag_a;
    logic [30:0] mag_b;
    logic        both_zero;
    logic        any_nan;
    logic        any_snan;
    logic        is_eq;
    logic        is_lt;
    logic        is_le;
    logic        res_sel;
    logic        nv_sel;

    fp_classify u_cls_a (
        .pclk (pclk),
        .a    (cmp_req.a),
        .cls  (cls_a)
    );

    fp_classify u_cls_b (
        .pclk (pclk),
        .a    (cmp_req.b),
        .cls  (cls_b)
    );

    assign mag_a = cmp_req.a[30:0];
    assign mag_b = cmp_req.b[30:0];

    assign both_zero = cls_a.is_zero && cls_b.is_zero;
    assign any_nan   = cls_a.is_nan || cls_b.is_nan;
    assign any_snan  = cls_a.is_snan || cls_b.is_snan;

    // Bit-identical values are equal, and so are the two signed zeros
    assign is_eq = (cmp_req.a == cmp_req.b) || both_zero;

    // In sign-magnitude ordering the negatives reverse the magnitude order
    always_comb begin
        if (cls_a.sign != cls_b.sign) begin
            is_lt = cls_a.sign && !both_zero;
        end else if (!cls_a.sign) begin
            is_lt = mag_a < mag_b;
        end else begin
            is_lt = mag_a > mag_b;
        end
    end

    assign is_le = is_lt || is_eq;

    // feq is quiet and flags only sNaN while flt and fle flag any NaN
    always_comb begin
        res_sel = 1'b0;
        nv_sel  = 1'b0;
        case (cmp_req.op)
            CMP_FEQ: begin
                res_sel = is_eq && !any_nan;
                nv_sel  = any_snan;
            end
            CMP_FLT: begin
                res_sel = is_lt && !any_nan;
                nv_sel  = any_nan;
            end
            CMP_FLE: begin
                res_sel = is_le && !any_nan;
                nv_sel  = any_nan;
            end
            default: begin
                res_sel = 1'b0;
                nv_sel  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            cmp_rsp <= '0;
        end else begin
            cmp_rsp <= '{valid: cmp_req.valid, res: res_sel, nv: nv_sel};
        end
    end

    rsp_follows_req: assert property (
        @(posedge pclk) disable iff (!rst_n) cmp_rsp.valid == $past(cmp_req.valid)
    );

    req_op_legal: assert property (
        @(posedge pclk) disable iff (!rst_n)
        cmp_req.valid |-> (cmp_req.op inside {CMP_FEQ, CMP_FLT, CMP_FLE})
    );

endmodule

/* design/fcmp_apb_regs.sv */
`timescale 1ns/1ps

module fcmp_apb_regs #(
    parameter int ADDR_W = 8
) (
    input  logic                pclk,
    input  logic                rst_n,
    input  logic [ADDR_W-1:0]   paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  fcmp_pkg::apb_data_t pwdata,
    output fcmp_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr,
    output fcmp_pkg::cmp_req_t  cmp_req,
    input  fcmp_pkg::cmp_rsp_t  cmp_rsp
);

    import fcmp_pkg::*;

    logic      access;
    logic      wr_ok;
    logic      hit_opa;
    logic      hit_opb;
    logic      hit_cmd;
    logic      hit_res;
    logic      hit_flg;
    logic      mapped;
    logic      cmd_legal;
    logic      launch;
    logic      nv_clr;
    logic      nv_set;
    logic      res_rd;
    logic      done_rd;
    logic      nv_rd;

    fp32_t     opa_q;
    fp32_t     opb_q;
    fcmp_op_e  cmd_q;
    logic      launch_q;
    logic      res_q;
    logic      done_q;
    logic      nv_q;

    assign access = psel && penable;

    assign hit_opa = (paddr == ADDR_W'(REG_OPA));
    assign hit_opb = (paddr == ADDR_W'(REG_OPB));
    assign hit_cmd = (paddr == ADDR_W'(REG_CMD));
    assign hit_res = (paddr == ADDR_W'(REG_RESULT));
    assign hit_flg = (paddr == ADDR_W'(REG_FFLAGS));
    assign mapped  = hit_opa || hit_opb || hit_cmd || hit_res || hit_flg;

    assign cmd_legal = (pwdata[1:0] != 2'b11);

    // With no wait states the errors are flagged in the access cycle itself
    assign pready  = 1'b1;
    assign pslverr = access && (!mapped ||
                                (pwrite && hit_res) ||
                                (pwrite && hit_cmd && !cmd_legal));

    assign wr_ok  = access && pwrite && !pslverr;
    assign launch = wr_ok && hit_cmd;
    assign nv_clr = wr_ok && hit_flg && pwdata[FFLAGS_NV_BIT];
    assign nv_set = cmp_rsp.valid && cmp_rsp.nv;

    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            opa_q    <= '0;
            opb_q    <= '0;
            cmd_q    <= CMP_FEQ;
            launch_q <= 1'b0;
        end else begin
            if (wr_ok && hit_opa) begin
                opa_q <= pwdata;
            end
            if (wr_ok && hit_opb) begin
                opb_q <= pwdata;
            end
            if (launch) begin
                cmd_q <= fcmp_op_e'(pwdata[1:0]);
            end
            launch_q <= launch;
        end
    end

    // A new launch clears done even if an older response lands in the same cycle
    always_ff @(posedge pclk or negedge rst_n) begin
        if (!rst_n) begin
            res_q  <= 1'b0;
            done_q <= 1'b0;
            nv_q   <= 1'b0;
        end else begin
            if (launch) begin
                done_q <= 1'b0;
            end else if (cmp_rsp.valid) begin
                done_q <= 1'b1;
                res_q  <= cmp_rsp.res;
            end
            nv_q <= (nv_q && !nv_clr) || nv_set;
        end
    end

    assign cmp_req = '{valid: launch_q, op: cmd_q, a: opa_q, b: opb_q};

    // The response can arrive in the access cycle of the very next read,
    // so it is forwarded to the read data alongside the stored state
    assign res_rd  = cmp_rsp.valid ? cmp_rsp.res : res_q;
    assign done_rd = done_q || cmp_rsp.valid;
    assign nv_rd   = nv_q || nv_set;

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (hit_opa) begin
                prdata = opa_q;
            end else if (hit_opb) begin
                prdata = opb_q;
            end else if (hit_cmd) begin
                prdata = apb_data_t'(cmd_q);
            end else if (hit_res) begin
                prdata[RESULT_RES_BIT]  = res_rd;
                prdata[RESULT_DONE_BIT] = done_rd;
            end else if (hit_flg) begin
                prdata[FFLAGS_NV_BIT] = nv_rd;
            end
        end
    end

    penable_needs_psel: assert property (
        @(posedge pclk) disable iff (!rst_n) penable |-> psel
    );

endmodule

/* design/fcmp_top.sv */
`timescale 1ns/1ps

module fcmp_top #(
    parameter int ADDR_W = 8
) (
    input  logic                pclk,
    input  logic                rst_n,
    input  logic [ADDR_W-1:0]   paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  fcmp_pkg::apb_data_t pwdata,
    output fcmp_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr
);

    import fcmp_pkg::*;

    cmp_req_t cmp_req;
    cmp_rsp_t cmp_rsp;

    fcmp_apb_regs #(
        .ADDR_W (ADDR_W)
    ) u_regs (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cmp_req (cmp_req),
        .cmp_rsp (cmp_rsp)
    );

    fp_compare u_cmp (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .cmp_req (cmp_req),
        .cmp_rsp (cmp_rsp)
    );

endmodule

/* bench/fcmp_tb.sv */
`timescale 1ns/1ps

module fcmp_tb;

    import fcmp_pkg::*;

    localparam int ADDR_W     = 8;
    localparam int RAND_PAIRS = 300;

    typedef struct packed {
        fcmp_op_e op;
        fp32_t    a;
        fp32_t    b;
        logic     res;
        logic     nv;
    } stim_vec_t;

    logic              pclk;
    logic              rst_n;
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    apb_data_t         pwdata;
    apb_data_t         prdata;
    logic              pready;
    logic              pslverr;

    stim_vec_t   vecs[$];
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 0;
    logic [31:0] lcg_state = 32'd21582;

    fcmp_top #(
        .ADDR_W (ADDR_W)
    ) UUT (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    always @(posedge pclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", cycle_cnt);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Operands are finite and now and then a signed zero
    function automatic fp32_t rand_operand();
        logic [31:0] hi;
        logic [31:0] lo;
        fp32_t       v;
        hi = lcg_next();
        lo = lcg_next();
        v = {hi[31:16], lo[31:16]};
        if (v[30:23] == 8'hFF) begin
            v[30:23] = 8'hFE;
        end
        if (hi[15:12] == 4'h0) begin
            v[30:0] = '0;
        end
        return v;
    endfunction

    // Each value is mapped to a signed key whose integer order is the float order,
    // with both zeros landing on key 0. Returns {result, nv}
    function automatic logic [1:0] ref_compare(input fcmp_op_e op, input fp32_t a,
                                               input fp32_t b);
        logic signed [32:0] key_a;
        logic signed [32:0] key_b;
        logic               nan_a;
        logic               nan_b;
        logic               snan_any;
        logic               res;
        logic               nv;
        nan_a = (a[30:23] == 8'hFF) && (a[22:0] != '0);
        nan_b = (b[30:23] == 8'hFF) && (b[22:0] != '0);
        snan_any = (nan_a && !a[22]) || (nan_b && !b[22]);
        key_a = a[31] ? -$signed({2'b00, a[30:0]}) : $signed({2'b00, a[30:0]});
        key_b = b[31] ? -$signed({2'b00, b[30:0]}) : $signed({2'b00, b[30:0]});
        case (op)
            CMP_FEQ: begin
                res = (key_a == key_b);
                nv  = snan_any;
            end
            CMP_FLT: begin
                res = (key_a < key_b);
                nv  = nan_a || nan_b;
            end
            CMP_FLE: begin
                res = (key_a <= key_b);
                nv  = nan_a || nan_b;
            end
            default: begin
                res = 1'b0;
                nv  = 1'b0;
            end
        endcase
        if (nan_a || nan_b) begin
            res = 1'b0;
        end
        return {res, nv};
    endfunction

    task automatic check_result(input fcmp_op_e op, input logic exp_res, input logic act_res);
        if (exp_res !== act_res) begin
            fail_cnt++;
            $display("Mismatch at %0t: result of %s expected %0b, got %0b",
                     $time, op.name(), exp_res, act_res);
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_flags(input apb_data_t exp_flags, input apb_data_t act_flags);
        if (exp_flags !== act_flags) begin
            fail_cnt++;
            $display("Mismatch at %0t: REG_FFLAGS expected %08h, got %08h",
                     $time, exp_flags, act_flags);
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_data(input string name, input apb_data_t exp_data,
                              input apb_data_t act_data);
        if (exp_data !== act_data) begin
            fail_cnt++;
            $display("Mismatch at %0t: %s expected %08h, got %08h",
                     $time, name, exp_data, act_data);
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_err(input logic exp_err, input logic act_err);
        if (exp_err !== act_err) begin
            fail_cnt++;
            $display("Mismatch at %0t: pslverr at address %02h expected %0b, got %0b",
                     $time, paddr, exp_err, act_err);
        end else begin
            pass_cnt++;
        end
    endtask

    // The slave has no wait states, so pready is high in every access cycle
    task automatic check_ready(input logic act_ready);
        if (act_ready !== 1'b1) begin
            fail_cnt++;
            $display("Mismatch at %0t: pready at address %02h expected 1, got %0b",
                     $time, paddr, act_ready);
        end else begin
            pass_cnt++;
        end
    endtask

    // Bus tasks are entered 1 ns after a rising edge and leave at the same point
    task automatic apb_write(input logic [ADDR_W-1:0] addr, input apb_data_t data,
                             input logic exp_err);
        paddr   = addr;
        pwrite  = 1'b1;
        pwdata  = data;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge pclk);
        #1;
        penable = 1'b1;
        @(negedge pclk);
        check_ready(pready);
        check_err(exp_err, pslverr);
        @(posedge pclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [ADDR_W-1:0] addr, output apb_data_t data,
                            input logic exp_err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge pclk);
        #1;
        penable = 1'b1;
        @(negedge pclk);
        data = prdata;
        check_ready(pready);
        check_err(exp_err, pslverr);
        @(posedge pclk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic launch_compare(input fcmp_op_e op, output apb_data_t rd);
        apb_write(REG_CMD, apb_data_t'(op), 1'b0);
        apb_read(REG_RESULT, rd, 1'b0);
        check_data("REG_RESULT.done", 32'd1, apb_data_t'(rd[RESULT_DONE_BIT]));
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("Test %-14s finished at %0t with %0d errors",
                 name, $time, fail_cnt - fails_before);
    endtask

    task automatic load_vectors();
        int                fd;
        int                code;
        logic [8*128-1:0]  line;
        logic [31:0]       f_cmd;
        logic [31:0]       f_a;
        logic [31:0]       f_b;
        logic [31:0]       f_res;
        logic [31:0]       f_nv;
        stim_vec_t         v;
        fd = $fopen("bench/fcmp_stim.txt", "r");
        if (fd == 0) begin
            fail_cnt++;
            $display("Error: could not open the stimulus file bench/fcmp_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(line, fd);
                if (code > 0) begin
                    // Comment and blank lines do not scan as five fields
                    code = $sscanf(line, "%h %h %h %h %h", f_cmd, f_a, f_b, f_res, f_nv);
                    if (code == 5) begin
                        v.op  = fcmp_op_e'(f_cmd[1:0]);
                        v.a   = f_a;
                        v.b   = f_b;
                        v.res = f_res[0];
                        v.nv  = f_nv[0];
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
            if (vecs.size() == 0) begin
                fail_cnt++;
                $display("Error: the stimulus file holds no test vectors");
            end
        end
    endtask

    // Transfers are 5 for reset, 4 readback, 6 per vector, 12 sticky NV,
    // 9 per random pair and 10 for the slave errors
    function automatic int transfers_needed(input int n_vec);
        return 5 + 4 + 6 * n_vec + 12 + 9 * RAND_PAIRS + 10;
    endfunction

    task automatic test_reset_values();
        int        fails_before;
        apb_data_t rd;
        fails_before = fail_cnt;
        apb_read(REG_OPA, rd, 1'b0);
        check_data("REG_OPA", 32'h0, rd);
        apb_read(REG_OPB, rd, 1'b0);
        check_data("REG_OPB", 32'h0, rd);
        apb_read(REG_CMD, rd, 1'b0);
        check_data("REG_CMD", 32'h0, rd);
        apb_read(REG_RESULT, rd, 1'b0);
        check_data("REG_RESULT", 32'h0, rd);
        apb_read(REG_FFLAGS, rd, 1'b0);
        check_flags(32'h0, rd);
        report_test("reset_values", fails_before);
    endtask

    task automatic test_readback();
        int        fails_before;
        apb_data_t rd;
        fails_before = fail_cnt;
        apb_write(REG_OPA, 32'h1234_5678, 1'b0);
        apb_write(REG_OPB, 32'h89AB_CDEF, 1'b0);
        apb_read(REG_OPA, rd, 1'b0);
        check_data("REG_OPA", 32'h1234_5678, rd);
        apb_read(REG_OPB, rd, 1'b0);
        check_data("REG_OPB", 32'h89AB_CDEF, rd);
        report_test("readback", fails_before);
    endtask

    task automatic test_directed();
        int        fails_before;
        apb_data_t rd;
        fails_before = fail_cnt;
        foreach (vecs[i]) begin
            apb_write(REG_OPA, vecs[i].a, 1'b0);
            apb_write(REG_OPB, vecs[i].b, 1'b0);
            launch_compare(vecs[i].op, rd);
            check_result(vecs[i].op, vecs[i].res, rd[RESULT_RES_BIT]);
            apb_read(REG_FFLAGS, rd, 1'b0);
            check_flags(apb_data_t'(vecs[i].nv), rd);
            // Start every vector with NV clear
            apb_write(REG_FFLAGS, 32'h1, 1'b0);
        end
        report_test("directed", fails_before);
    endtask

    task automatic test_sticky_nv();
        int        fails_before;
        apb_data_t rd;
        fails_before = fail_cnt;
        apb_write(REG_OPA, 32'h7FC0_0000, 1'b0);
        apb_write(REG_OPB, 32'h3F80_0000, 1'b0);
        launch_compare(CMP_FLT, rd);
        check_result(CMP_FLT, 1'b0, rd[RESULT_RES_BIT]);
        apb_read(REG_FFLAGS, rd, 1'b0);
        check_flags(32'h1, rd);
        apb_write(REG_OPA, 32'h3F80_0000, 1'b0);
        apb_write(REG_OPB, 32'h4000_0000, 1'b0);
        launch_compare(CMP_FLT, rd);
        check_result(CMP_FLT, 1'b1, rd[RESULT_RES_BIT]);
        apb_read(REG_FFLAGS, rd, 1'b0);
        check_flags(32'h1, rd);
        apb_write(REG_FFLAGS, 32'h1, 1'b0);
        apb_read(REG_FFLAGS, rd, 1'b0);
        check_flags(32'h0, rd);
        report_test("sticky_nv", fails_before);
    endtask

    task automatic test_random();
        int         fails_before;
        fp32_t      a;
        fp32_t      b;
        fcmp_op_e   op;
        logic [1:0] exp;
        logic       nv_any;
        apb_data_t  rd;
        fails_before = fail_cnt;
        for (int i = 0; i < RAND_PAIRS; i++) begin
            a = rand_operand();
            if (i % 2 == 0) begin
                b = a;
                // An equal zero pair gets the opposite sign
                if (a[30:0] == '0) begin
                    b[31] = ~a[31];
                end
            end else if (i % 4 == 1) begin
                b = a ^ 32'h1;
            end else begin
                b = rand_operand();
            end
            nv_any = 1'b0;
            apb_write(REG_OPA, a, 1'b0);
            apb_write(REG_OPB, b, 1'b0);
            for (int k = 0; k < 3; k++) begin
                op = fcmp_op_e'(k[1:0]);
                exp = ref_compare(op, a, b);
                nv_any = nv_any | exp[0];
                launch_compare(op, rd);
                check_result(op, exp[1], rd[RESULT_RES_BIT]);
            end
            apb_read(REG_FFLAGS, rd, 1'b0);
            check_flags(apb_data_t'(nv_any), rd);
        end
        report_test("random", fails_before);
    endtask

    task automatic test_slave_errors();
        int        fails_before;
        apb_data_t rd;
        fails_before = fail_cnt;
        apb_write(REG_OPA, 32'h3F80_0000, 1'b0);
        apb_write(REG_OPB, 32'h4000_0000, 1'b0);
        launch_compare(CMP_FLT, rd);
        check_result(CMP_FLT, 1'b1, rd[RESULT_RES_BIT]);
        // Code 3 must leave CMD, done and result as they were
        apb_write(REG_CMD, 32'h3, 1'b1);
        apb_read(REG_CMD, rd, 1'b0);
        check_data("REG_CMD", 32'h1, rd);
        apb_read(REG_RESULT, rd, 1'b0);
        check_data("REG_RESULT", 32'h3, rd);
        apb_write(REG_RESULT, 32'h0, 1'b1);
        apb_read(8'h14, rd, 1'b1);
        apb_write(8'h40, 32'hFFFF_FFFF, 1'b1);
        report_test("slave_errors", fails_before);
    endtask

    initial begin
        rst_n   = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        load_vectors();
        cycle_limit = 10 * transfers_needed(vecs.size()) * 2;
        repeat (4) @(posedge pclk);
        #1;
        rst_n = 1'b1;
        test_reset_values();
        test_readback();
        test_directed();
        test_sticky_nv();
        test_random();
        test_slave_errors();
        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
design/fcmp_pkg.sv
design/fp_classify.sv
design/fp_compare.sv
design/fcmp_apb_regs.sv
design/fcmp_top.sv
bench/fcmp_tb.sv

/* Makefile */
# Verilator build, run and lint for the floating-point compare unit

VERILATOR  ?= verilator
TOP        ?= fcmp_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 0
VFLAGS     ?= --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= -Wall
PASS_MSG   ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

# The simulation output is kept in a shell variable and searched for the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --timing --timescale 1ns/1ps \
		-f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* bench/fcmp_stim.txt */
# cmd (0 feq, 1 flt, 2 fle)  operand a  operand b  expected result  expected nv
# All fields are hex
0 3F800000 3F800000 1 0
1 3F800000 3F800000 0 0
2 3F800000 3F800000 1 0
0 00000000 80000000 1 0
1 00000000 80000000 0 0
2 80000000 00000000 1 0
1 80000000 00000000 0 0
1 BF800000 3F800000 1 0
1 3F800000 BF800000 0 0
2 BF800000 3F800000 1 0
0 BF800000 3F800000 0 0
1 C0000000 BF800000 1 0
1 BF800000 C0000000 0 0
2 C0000000 BF800000 1 0
2 BF800000 C0000000 0 0
1 3F800000 40000000 1 0
2 40000000 3F800000 0 0
1 3FA00000 3FC00000 1 0
1 3FC00000 3FA00000 0 0
2 3FC00000 3FA00000 0 0
0 3FA00000 3FC00000 0 0
1 BFC00000 BFA00000 1 0
2 BFA00000 BFC00000 0 0
1 00000001 00000002 1 0
1 80000001 00000000 1 0
1 80000000 00000001 1 0
1 FF800000 7F800000 1 0
1 7F800000 7F7FFFFF 0 0
2 7F7FFFFF 7F800000 1 0
0 7F800000 7F800000 1 0
2 FF800000 FF800000 1 0
1 FF800000 FF7FFFFF 1 0
0 7FC00000 3F800000 0 0
1 7FC00000 3F800000 0 1
2 3F800000 7FC00000 0 1
0 7F800001 3F800000 0 1
1 7F800001 3F800000 0 1
2 3F800000 7F800001 0 1
0 7FC00000 7FC00000 0 0
0 FFC00000 7F800001 0 1
1 7FC00000 7FC00000 0 1
0 7FA00000 7FA00000 0 1
